// File: src/ec_consts.svh
/* Curve and field constants */

`ifndef EC_CONSTS_SVH
`define EC_CONSTS_SVH

// Field prime, largest 16-bit prime
`define EC_P 16'd65521

// Width of one field element
`define EC_BITS 16

// Curve coefficient a in y^2 = x^3 + a*x + b
`define EC_A 16'd3

// Scalar width for point multiplication
`define EC_K_BITS 16

`endif

// File: src/ec_pkg.sv
/* Field element types */

`include "ec_consts.svh"

package ec_pkg;

  // One coordinate, kept fully reduced below EC_P
  typedef logic [`EC_BITS-1:0] fe_t;

endpackage

// File: src/fp_mod_mult.sv
/* Shift-and-add modular multiplier */

`timescale 1ns/1ns

`include "ec_consts.svh"

module fp_mod_mult (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_start, // Operands sampled here
  input  ec_pkg::fe_t i_a,
  input  ec_pkg::fe_t i_b,
  output logic        o_done,  // Exactly EC_BITS+1 cycles after i_start
  output ec_pkg::fe_t o_p
);

  localparam int SW    = `EC_BITS + 2;          // Room for 2*acc + a
  localparam int CNT_W = $clog2(`EC_BITS);
  localparam logic [SW-1:0] P1 = SW'(`EC_P);
  localparam logic [SW-1:0] P2 = SW'(2 * `EC_P);

  ec_pkg::fe_t      a_q;     // Multiplicand
  ec_pkg::fe_t      b_sh;    // Multiplier, scanned from the MSB
  ec_pkg::fe_t      acc;     // Running product, always below EC_P
  logic [CNT_W-1:0] cnt;
  logic             busy;
  logic             done;
  logic [SW-1:0]    sum;
  logic [SW-1:0]    sum_red;

  // Double, add, then pull back into range
  always_comb begin
    sum = {1'b0, acc, 1'b0} + (b_sh[`EC_BITS-1] ? {2'b00, a_q} : '0);
    if (sum >= P2) begin
      sum_red = sum - P2;
    end else if (sum >= P1) begin
      sum_red = sum - P1;
    end else begin
      sum_red = sum;
    end
  end

  // Datapath
  always_ff @(posedge i_clk) begin
    if (i_start) begin
      a_q  <= i_a;
      b_sh <= i_b;
      acc  <= '0;
      cnt  <= '0;
    end else if (busy) begin
      acc  <= sum_red[`EC_BITS-1:0];
      b_sh <= b_sh << 1;          // Next bit into the MSB
      cnt  <= cnt + 1'b1;
    end
  end

  // Control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
      end else if (busy && cnt == CNT_W'(`EC_BITS - 1)) begin
        busy <= 1'b0;             // Last bit folded in this cycle
        done <= 1'b1;
      end
    end
  end

  assign o_done = done;
  assign o_p    = acc;           // Holds until the next start

endmodule

// File: src/ec_point_unit.sv
/* Affine point doubler or adder */

`timescale 1ns/1ns

`include "ec_consts.svh"

module ec_point_unit #(
  parameter int DOUBLE = 0     // 1 doubles (x1,y1), 0 adds the two points
) (
  input  logic        i_clk,
  input  logic        i_rst,
  input  logic        i_cmd_val,
  output logic        o_cmd_rdy,
  input  ec_pkg::fe_t i_x1,
  input  ec_pkg::fe_t i_y1,
  input  ec_pkg::fe_t i_x2,
  input  ec_pkg::fe_t i_y2,
  output logic        o_res_val,
  input  logic        i_res_rdy,
  output ec_pkg::fe_t o_res_x,
  output ec_pkg::fe_t o_res_y
);

  localparam int IDX_W = $clog2(`EC_BITS);
  localparam ec_pkg::fe_t EXP = `EC_P - 16'd2;   // Fermat exponent for the inverse

  typedef enum logic [2:0] {S_IDLE, S_NUM, S_INV, S_LAM, S_SQ, S_Y, S_DONE} state_t;

  state_t           state;
  ec_pkg::fe_t      x1_q, y1_q, x2_q;
  ec_pkg::fe_t      num, den, lam;
  ec_pkg::fe_t      res_x, res_y;
  ec_pkg::fe_t      mul_a, mul_b, mul_p;
  ec_pkg::fe_t      x3_c;
  logic             mul_start, mul_done;
  logic             res_val;
  logic [IDX_W-1:0] bit_idx;  // Exponent bit being processed
  logic             sq_phase; // 1 while the square of a bit is running

  function automatic ec_pkg::fe_t mod_add(input ec_pkg::fe_t a, input ec_pkg::fe_t b);
    logic [`EC_BITS:0] s;
    s = a + b;
    if (s >= `EC_P) s = s - `EC_P;
    return s[`EC_BITS-1:0];
  endfunction

  function automatic ec_pkg::fe_t mod_sub(input ec_pkg::fe_t a, input ec_pkg::fe_t b);
    logic [`EC_BITS:0] d;
    d = {1'b0, a} - {1'b0, b};
    if (d[`EC_BITS]) d = d + `EC_P; // Borrow, wrap back into the field
    return d[`EC_BITS-1:0];
  endfunction

  fp_mod_mult u_mult (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_start (mul_start),
    .i_a     (mul_a),
    .i_b     (mul_b),
    .o_done  (mul_done),
    .o_p     (mul_p)
  );

  // x3 = lambda^2 - x1 - x2, valid while the square finishes
  assign x3_c = mod_sub(mod_sub(mul_p, x1_q), x2_q);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= S_IDLE;
      res_val   <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      mul_start <= 1'b0;  // Single-cycle strobe
      case (state)
        S_IDLE: begin
          if (i_cmd_val) begin
            x1_q     <= i_x1;
            y1_q     <= i_y1;
            bit_idx  <= IDX_W'(`EC_BITS - 2); // Top exponent bit is set, start with r = den
            sq_phase <= 1'b1;
            if (DOUBLE != 0) begin
              x2_q  <= i_x1;
              den   <= mod_add(i_y1, i_y1);   // 2y
              mul_a <= i_x1;                  // x^2 first
              mul_b <= i_x1;
              if (i_y1 == '0) begin
                // Infinity or a point of order 2
                res_x   <= '0;
                res_y   <= '0;
                res_val <= 1'b1;
                state   <= S_DONE;
              end else begin
                mul_start <= 1'b1;
                state     <= S_NUM;
              end
            end else begin
              x2_q  <= i_x2;
              num   <= mod_sub(i_y2, i_y1);
              den   <= mod_sub(i_x2, i_x1);
              mul_a <= mod_sub(i_x2, i_x1);   // Inversion starts by squaring den
              mul_b <= mod_sub(i_x2, i_x1);
              if (i_x1 == '0 && i_y1 == '0) begin
                res_x   <= i_x2;               // inf + P2 = P2
                res_y   <= i_y2;
                res_val <= 1'b1;
                state   <= S_DONE;
              end else if (i_x2 == '0 && i_y2 == '0) begin
                res_x   <= i_x1;
                res_y   <= i_y1;
                res_val <= 1'b1;
                state   <= S_DONE;
              end else if (i_x1 == i_x2) begin
                // P + (-P), equal points never reach the adder
                res_x   <= '0;
                res_y   <= '0;
                res_val <= 1'b1;
                state   <= S_DONE;
              end else begin
                mul_start <= 1'b1;
                state     <= S_INV;
              end
            end
          end
        end
        S_NUM: if (mul_done) begin
          num       <= mod_add(mod_add(mod_add(mul_p, mul_p), mul_p), `EC_A); // 3x^2 + a
          mul_a     <= den;
          mul_b     <= den;
          mul_start <= 1'b1;
          state     <= S_INV;
        end
        S_INV: if (mul_done) begin
          // Square-and-multiply, MSB first
          if (sq_phase && EXP[bit_idx]) begin
            mul_a     <= mul_p;
            mul_b     <= den;
            sq_phase  <= 1'b0;
            mul_start <= 1'b1;
          end else if (bit_idx == '0) begin
            mul_a     <= num;                  // mul_p is 1/den here
            mul_b     <= mul_p;
            mul_start <= 1'b1;
            state     <= S_LAM;
          end else begin
            bit_idx   <= bit_idx - 1'b1;
            mul_a     <= mul_p;
            mul_b     <= mul_p;
            sq_phase  <= 1'b1;
            mul_start <= 1'b1;
          end
        end
        S_LAM: if (mul_done) begin
          lam       <= mul_p;
          mul_a     <= mul_p;                  // lambda^2
          mul_b     <= mul_p;
          mul_start <= 1'b1;
          state     <= S_SQ;
        end
        S_SQ: if (mul_done) begin
          res_x     <= x3_c;
          mul_a     <= lam;                    // lambda * (x1 - x3)
          mul_b     <= mod_sub(x1_q, x3_c);
          mul_start <= 1'b1;
          state     <= S_Y;
        end
        S_Y: if (mul_done) begin
          res_y   <= mod_sub(mul_p, y1_q);
          res_val <= 1'b1;
          state   <= S_DONE;
        end
        S_DONE: if (i_res_rdy) begin
          res_val <= 1'b0;                     // Result held until taken
          state   <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign o_cmd_rdy = (state == S_IDLE);
  assign o_res_val = res_val;
  assign o_res_x   = res_x;
  assign o_res_y   = res_y;

endmodule

// File: src/ec_point_mult.sv
/* Double-and-add scalar multiplier control */

`timescale 1ns/1ns

`include "ec_consts.svh"

module ec_point_mult (
  input  logic                  i_clk,
  input  logic                  i_rst,
  // Request
  input  logic                  i_req_val,
  output logic                  o_req_rdy,
  input  ec_pkg::fe_t           i_req_x,
  input  ec_pkg::fe_t           i_req_y,
  input  logic [`EC_K_BITS-1:0] i_req_k,
  // Result
  output logic                  o_res_val,
  input  logic                  i_res_rdy,
  output ec_pkg::fe_t           o_res_x,
  output ec_pkg::fe_t           o_res_y,
  // Doubler
  output logic                  o_dbl_val,
  input  logic                  i_dbl_rdy,
  output ec_pkg::fe_t           o_dbl_x,
  output ec_pkg::fe_t           o_dbl_y,
  input  logic                  i_dblr_val,
  output logic                  o_dblr_rdy,
  input  ec_pkg::fe_t           i_dblr_x,
  input  ec_pkg::fe_t           i_dblr_y,
  // Adder
  output logic                  o_add_val,
  input  logic                  i_add_rdy,
  output ec_pkg::fe_t           o_add_x1,
  output ec_pkg::fe_t           o_add_y1,
  output ec_pkg::fe_t           o_add_x2,
  output ec_pkg::fe_t           o_add_y2,
  input  logic                  i_addr_val,
  output logic                  o_addr_rdy,
  input  ec_pkg::fe_t           i_addr_x,
  input  ec_pkg::fe_t           i_addr_y
);

  typedef enum logic [1:0] {IDLE, DOUBLE_ADD, FINISHED} state_t;

  state_t                state;
  logic [`EC_K_BITS-1:0] k_l;          // Remaining scalar bits
  ec_pkg::fe_t           acc_x, acc_y; // Accumulator, (0,0) is infinity
  ec_pkg::fe_t           dbl_x, dbl_y; // Current 2^i * P
  logic                  p_dbl_done, p_add_done;
  logic                  special_dbl;  // Next doubler result becomes the accumulator
  logic                  lookahead_dbl;
  logic                  same_pt;
  logic                  more_bits;

  assign same_pt   = (acc_x == dbl_x) && (acc_y == dbl_y);
  assign more_bits = (k_l >> 1) != '0; // A bit after the next one

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state         <= IDLE;
      k_l           <= '0;
      o_req_rdy     <= 1'b0;
      o_res_val     <= 1'b0;
      o_dbl_val     <= 1'b0;
      o_add_val     <= 1'b0;
      o_dblr_rdy    <= 1'b0;
      o_addr_rdy    <= 1'b0;
      p_dbl_done    <= 1'b0;
      p_add_done    <= 1'b0;
      special_dbl   <= 1'b0;
      lookahead_dbl <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          o_req_rdy     <= 1'b1;
          o_dblr_rdy    <= 1'b1;
          o_addr_rdy    <= 1'b1;
          p_dbl_done    <= 1'b1;  // First pass issues straight away
          p_add_done    <= 1'b1;
          special_dbl   <= 1'b0;
          lookahead_dbl <= 1'b0;
          acc_x         <= '0;
          acc_y         <= '0;
          dbl_x         <= i_req_x;
          dbl_y         <= i_req_y;
          k_l           <= i_req_k;
          if (i_req_val && o_req_rdy) begin
            o_req_rdy <= 1'b0;
            state     <= DOUBLE_ADD;
          end
        end
        DOUBLE_ADD: begin
          if (o_dbl_val && i_dbl_rdy) o_dbl_val <= 1'b0;
          if (o_add_val && i_add_rdy) o_add_val <= 1'b0;

          if (i_dblr_val && o_dblr_rdy) begin
            p_dbl_done <= 1'b1;
            dbl_x      <= i_dblr_x;
            dbl_y      <= i_dblr_y;
            if (special_dbl) begin
              acc_x       <= i_dblr_x; // P + P taken from the doubler
              acc_y       <= i_dblr_y;
              special_dbl <= 1'b0;
            end
            // Start the next double while the add is still running
            if (more_bits && !lookahead_dbl && !p_add_done) begin
              o_dbl_val     <= 1'b1;
              lookahead_dbl <= 1'b1;
              o_dblr_rdy    <= 1'b0;   // Hold that result until the add lands
            end
          end
          if (i_addr_val && o_addr_rdy) begin
            p_add_done <= 1'b1;
            acc_x      <= i_addr_x;
            acc_y      <= i_addr_y;
          end

          // Both units settled, move to the next bit
          if (p_add_done && p_dbl_done) begin
            lookahead_dbl <= 1'b0;
            o_dblr_rdy    <= 1'b1;
            p_dbl_done    <= 1'b0;
            k_l           <= k_l >> 1;
            if (k_l[0] && same_pt) begin
              special_dbl <= 1'b1;     // Adder cannot take equal points
            end else if (k_l[0]) begin
              o_add_val  <= 1'b1;
              p_add_done <= 1'b0;
            end
            // Last bit needs no double unless the accumulator waits on it
            if (more_bits || (k_l[0] && same_pt)) begin
              o_dbl_val <= ~lookahead_dbl;
            end else begin
              p_dbl_done <= 1'b1;
            end
            if (k_l == '0) begin
              o_res_val <= 1'b1;
              o_dbl_val <= 1'b0;
              o_add_val <= 1'b0;
              state     <= FINISHED;
            end
          end
        end
        FINISHED: begin
          if (o_res_val && i_res_rdy) begin
            o_res_val <= 1'b0;
            state     <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign o_dbl_x  = dbl_x;
  assign o_dbl_y  = dbl_y;
  assign o_add_x1 = acc_x;
  assign o_add_y1 = acc_y;
  assign o_add_x2 = dbl_x;   // Second addend is always the doubling point
  assign o_add_y2 = dbl_y;
  assign o_res_x  = acc_x;   // Accumulator is frozen in FINISHED
  assign o_res_y  = acc_y;

endmodule

// File: src/ec_mult_top.sv
/* Point multiplier top */

`timescale 1ns/1ns

`include "ec_consts.svh"

module ec_mult_top (
  input  logic                  i_clk,
  input  logic                  i_rst,
  input  logic                  i_req_val,
  output logic                  o_req_rdy,
  input  ec_pkg::fe_t           i_req_x,
  input  ec_pkg::fe_t           i_req_y,
  input  logic [`EC_K_BITS-1:0] i_req_k,
  output logic                  o_res_val,
  input  logic                  i_res_rdy,
  output ec_pkg::fe_t           o_res_x,
  output ec_pkg::fe_t           o_res_y
);

  logic        dbl_cmd_val, dbl_cmd_rdy, dbl_res_val, dbl_res_rdy;
  logic        add_cmd_val, add_cmd_rdy, add_res_val, add_res_rdy;
  ec_pkg::fe_t dbl_x, dbl_y, dbl_res_x, dbl_res_y;
  ec_pkg::fe_t add_x1, add_y1, add_x2, add_y2, add_res_x, add_res_y;

  ec_point_mult u_ctrl (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_req_val (i_req_val), .o_req_rdy (o_req_rdy),
    .i_req_x (i_req_x), .i_req_y (i_req_y), .i_req_k (i_req_k),
    .o_res_val (o_res_val), .i_res_rdy (i_res_rdy),
    .o_res_x (o_res_x), .o_res_y (o_res_y),
    .o_dbl_val (dbl_cmd_val), .i_dbl_rdy (dbl_cmd_rdy),
    .o_dbl_x (dbl_x), .o_dbl_y (dbl_y),
    .i_dblr_val (dbl_res_val), .o_dblr_rdy (dbl_res_rdy),
    .i_dblr_x (dbl_res_x), .i_dblr_y (dbl_res_y),
    .o_add_val (add_cmd_val), .i_add_rdy (add_cmd_rdy),
    .o_add_x1 (add_x1), .o_add_y1 (add_y1), .o_add_x2 (add_x2), .o_add_y2 (add_y2),
    .i_addr_val (add_res_val), .o_addr_rdy (add_res_rdy),
    .i_addr_x (add_res_x), .i_addr_y (add_res_y)
  );

  // Second pair unused by the doubler
  ec_point_unit #(.DOUBLE(1)) u_dbl (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_cmd_val (dbl_cmd_val), .o_cmd_rdy (dbl_cmd_rdy),
    .i_x1 (dbl_x), .i_y1 (dbl_y), .i_x2 (dbl_x), .i_y2 (dbl_y),
    .o_res_val (dbl_res_val), .i_res_rdy (dbl_res_rdy),
    .o_res_x (dbl_res_x), .o_res_y (dbl_res_y)
  );

  ec_point_unit #(.DOUBLE(0)) u_add (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_cmd_val (add_cmd_val), .o_cmd_rdy (add_cmd_rdy),
    .i_x1 (add_x1), .i_y1 (add_y1), .i_x2 (add_x2), .i_y2 (add_y2),
    .o_res_val (add_res_val), .i_res_rdy (add_res_rdy),
    .o_res_x (add_res_x), .o_res_y (add_res_y)
  );

endmodule

// File: test/ec_ref_model.svh
/* Reference model for field and curve arithmetic */

`ifndef EC_REF_MODEL_SVH
`define EC_REF_MODEL_SVH

// Points travel packed as {x, y}, and (0,0) is the point at infinity

function automatic ec_pkg::fe_t add_mod(input ec_pkg::fe_t a, input ec_pkg::fe_t b);
  logic [31:0] t;
  t = 32'(a) + 32'(b);
  return ec_pkg::fe_t'(t % 32'(`EC_P));
endfunction

function automatic ec_pkg::fe_t sub_mod(input ec_pkg::fe_t a, input ec_pkg::fe_t b);
  logic [31:0] t;
  t = 32'(a) + 32'(`EC_P) - 32'(b);  // Lifted by P so it never goes negative
  return ec_pkg::fe_t'(t % 32'(`EC_P));
endfunction

function automatic ec_pkg::fe_t mul_mod(input ec_pkg::fe_t a, input ec_pkg::fe_t b);
  logic [31:0] t;
  t = 32'(a) * 32'(b);               // Fits, both operands below 2^16
  return ec_pkg::fe_t'(t % 32'(`EC_P));
endfunction

// Fermat inverse, exponent scanned from the LSB
function automatic ec_pkg::fe_t inv_mod(input ec_pkg::fe_t a);
  ec_pkg::fe_t r;
  ec_pkg::fe_t base;
  ec_pkg::fe_t e;
  r    = ec_pkg::fe_t'(1);
  base = a;
  e    = `EC_P - 16'd2;
  for (int i = 0; i < `EC_BITS; i++) begin
    if (e[i]) r = mul_mod(r, base);
    base = mul_mod(base, base);
  end
  return r;
endfunction

function automatic logic [2*`EC_BITS-1:0] point_double(input logic [2*`EC_BITS-1:0] p);
  ec_pkg::fe_t x, y, lam, x3, y3;
  x = p[2*`EC_BITS-1:`EC_BITS];
  y = p[`EC_BITS-1:0];
  if (y == '0) return '0;            // Infinity, or a point of order two
  lam = mul_mod(add_mod(mul_mod(ec_pkg::fe_t'(3), mul_mod(x, x)), `EC_A),
                inv_mod(add_mod(y, y)));
  x3  = sub_mod(sub_mod(mul_mod(lam, lam), x), x);
  y3  = sub_mod(mul_mod(lam, sub_mod(x, x3)), y);
  return {x3, y3};
endfunction

function automatic logic [2*`EC_BITS-1:0] point_add(input logic [2*`EC_BITS-1:0] p1,
                                                    input logic [2*`EC_BITS-1:0] p2);
  ec_pkg::fe_t x1, y1, x2, y2, lam, x3, y3;
  {x1, y1} = p1;
  {x2, y2} = p2;
  if (p1 == '0) return p2;
  if (p2 == '0) return p1;
  if (x1 == x2) return (y1 == y2) ? point_double(p1) : '0;  // Same point or P + (-P)
  lam = mul_mod(sub_mod(y2, y1), inv_mod(sub_mod(x2, x1)));
  x3  = sub_mod(sub_mod(mul_mod(lam, lam), x1), x2);
  y3  = sub_mod(mul_mod(lam, sub_mod(x1, x3)), y1);
  return {x3, y3};
endfunction

// k*P by double-and-add from the LSB
function automatic logic [2*`EC_BITS-1:0] mult_double_add(input logic [2*`EC_BITS-1:0] p,
                                                          input logic [`EC_K_BITS-1:0] k);
  logic [2*`EC_BITS-1:0] r, q;
  r = '0;
  q = p;
  for (int i = 0; i < `EC_K_BITS; i++) begin
    if (k[i]) r = point_add(r, q);
    q = point_double(q);
  end
  return r;
endfunction

// k*P by plain repeated addition, for small k
function automatic logic [2*`EC_BITS-1:0] mult_repeated(input logic [2*`EC_BITS-1:0] p,
                                                        input int k);
  logic [2*`EC_BITS-1:0] r;
  r = '0;
  for (int i = 0; i < k; i++) r = point_add(r, p);
  return r;
endfunction

`endif

// File: test/ec_mult_tb.sv
/* Scalar point multiplier testbench */

`timescale 1ns/1ns

`include "ec_consts.svh"

module ec_mult_tb;

  localparam int N_REQ = 33;  // Requests issued by all tests together
  // Requests x bits x point ops x multiplications x cycles x period, doubled
  localparam int WATCHDOG_NS = N_REQ * 17 * 2 * 25 * 18 * 100 * 2;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_req_val;
  logic                  o_req_rdy;
  ec_pkg::fe_t           i_req_x;
  ec_pkg::fe_t           i_req_y;
  logic [`EC_K_BITS-1:0] i_req_k;
  logic                  o_res_val;
  logic                  i_res_rdy;
  ec_pkg::fe_t           o_res_x;
  ec_pkg::fe_t           o_res_y;
  logic [31:0]           rng_state;  // LCG state

  `include "ec_ref_model.svh"

  ec_mult_top dut0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_req_val (i_req_val),
    .o_req_rdy (o_req_rdy),
    .i_req_x   (i_req_x),
    .i_req_y   (i_req_y),
    .i_req_k   (i_req_k),
    .o_res_val (o_res_val),
    .i_res_rdy (i_res_rdy),
    .o_res_x   (o_res_x),
    .o_res_y   (o_res_y)
  );

  always #50 i_clk = ~i_clk;  // 100 ns period

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic ec_pkg::fe_t rand_fe();
    logic [31:0] r;
    r = lcg_next();
    return ec_pkg::fe_t'((r >> 8) % 32'(`EC_P));  // Upper bits, low ones cycle fast
  endfunction

  function automatic logic [`EC_K_BITS-1:0] rand_k();
    logic [31:0] r;
    r = lcg_next();
    return r[31:32-`EC_K_BITS];
  endfunction

  function automatic logic [2*`EC_BITS-1:0] rand_point();
    ec_pkg::fe_t x, y;
    x = rand_fe();
    y = rand_fe();
    if (x == '0) x = ec_pkg::fe_t'(1);  // Keep clear of the infinity code
    return {x, y};
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_val(input string name, input ec_pkg::fe_t got, input ec_pkg::fe_t exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Reset for three cycles, then wait for the request channel to open
  task automatic reset_dut();
    int waited;
    i_rst = 1'b1;
    repeat (3) begin
      @(negedge i_clk);
      check_val("o_res_val", ec_pkg::fe_t'(o_res_val), '0);
    end
    i_rst  = 1'b0;
    waited = 0;
    while (!o_req_rdy && waited < 4) begin
      @(negedge i_clk);
      check_val("o_res_val", ec_pkg::fe_t'(o_res_val), '0);
      waited++;
    end
    if (!o_req_rdy) stop_with_failure("o_req_rdy stayed low after reset");
  endtask

  task automatic send_request(input logic [2*`EC_BITS-1:0] p, input logic [`EC_K_BITS-1:0] k);
    i_req_val = 1'b1;
    i_req_x   = p[2*`EC_BITS-1:`EC_BITS];
    i_req_y   = p[`EC_BITS-1:0];
    i_req_k   = k;
    while (!o_req_rdy) @(negedge i_clk);  // Registered ready, steady at the falling edge
    @(negedge i_clk);                     // Taken on the rising edge just passed
    i_req_val = 1'b0;
  endtask

  task automatic wait_result();
    while (!o_res_val) @(negedge i_clk);  // Bounded by the watchdog
  endtask

  task automatic run_request(input logic [2*`EC_BITS-1:0] p, input logic [`EC_K_BITS-1:0] k,
                             input logic [2*`EC_BITS-1:0] exp);
    send_request(p, k);
    wait_result();
    check_val("o_res_x", o_res_x, exp[2*`EC_BITS-1:`EC_BITS]);
    check_val("o_res_y", o_res_y, exp[`EC_BITS-1:0]);
    @(negedge i_clk);  // i_res_rdy is high, result taken
  endtask

  task automatic test_trivial();
    logic [2*`EC_BITS-1:0] p;
    p = rand_point();
    run_request(p, `EC_K_BITS'(1), p);
    run_request(p, '0, '0);           // k = 0 gives infinity
    run_request('0, rand_k(), '0);    // Infinity stays infinity
    run_request('0, '1, '0);          // Odd k, accumulator equals the doubling point
  endtask

  // Short scalars against plain repeated addition
  task automatic test_small();
    logic [2*`EC_BITS-1:0] p;
    int                    ks[4];
    ks = '{2, 3, 4, 7};
    p  = rand_point();
    foreach (ks[i]) run_request(p, `EC_K_BITS'(ks[i]), mult_repeated(p, ks[i]));
  endtask

  task automatic test_order2();
    ec_pkg::fe_t           x;
    logic [2*`EC_BITS-1:0] p;
    x = rand_fe();
    if (x == '0) x = ec_pkg::fe_t'(5);
    p = {x, ec_pkg::fe_t'(0)};        // y = 0, so 2P is infinity
    run_request(p, `EC_K_BITS'(2), '0);
    run_request(p, `EC_K_BITS'(3), p);
    // Doubler returns with the add, so the next double goes out early
    run_request(p, `EC_K_BITS'(7), p);
  endtask

  task automatic test_random();
    logic [2*`EC_BITS-1:0] p;
    logic [`EC_K_BITS-1:0] k;
    repeat (20) begin
      p = rand_point();
      k = rand_k();
      run_request(p, k, mult_double_add(p, k));
    end
  endtask

  task automatic test_backpressure();
    logic [2*`EC_BITS-1:0] p, exp;
    logic [`EC_K_BITS-1:0] k;
    ec_pkg::fe_t           hold_x, hold_y;
    int                    hold;
    p    = rand_point();
    k    = rand_k();
    exp  = mult_double_add(p, k);
    hold = 3 + int'(lcg_next() % 32'd10);
    i_res_rdy = 1'b0;
    send_request(p, k);
    wait_result();
    hold_x = o_res_x;
    hold_y = o_res_y;
    repeat (hold) begin
      @(negedge i_clk);
      check_val("o_res_val", ec_pkg::fe_t'(o_res_val), ec_pkg::fe_t'(1));
      check_val("o_res_x", o_res_x, hold_x);  // Must not move while stalled
      check_val("o_res_y", o_res_y, hold_y);
    end
    check_val("o_res_x", o_res_x, exp[2*`EC_BITS-1:`EC_BITS]);
    check_val("o_res_y", o_res_y, exp[`EC_BITS-1:0]);
    i_res_rdy = 1'b1;
    @(negedge i_clk);
    check_val("o_res_val", ec_pkg::fe_t'(o_res_val), '0);  // Dropped after the transfer
    p = rand_point();
    k = rand_k();
    run_request(p, k, mult_double_add(p, k));
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Watchdog expired before the tests finished");
  end

  initial begin
    rng_state = 32'h72a2_630c;
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_req_val = 1'b0;
    i_req_x   = '0;
    i_req_y   = '0;
    i_req_k   = '0;
    i_res_rdy = 1'b1;
    reset_dut();
    test_trivial();
    test_small();
    test_order2();
    test_random();
    test_backpressure();
    $display("Test passed");
    $finish;
  end

endmodule

// File: ec_mult.f
+incdir+src
+incdir+test
src/ec_pkg.sv
src/fp_mod_mult.sv
src/ec_point_unit.sv
src/ec_point_mult.sv
src/ec_mult_top.sv
test/ec_mult_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the point multiplier testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal -f ec_mult.f --top-module ec_mult_tb -o ec_mult_sim

# The simulator exits non-zero on a fatal check, keep its output for the search
out=$(./obj_dir/ec_mult_sim) || true
echo "$out"

if echo "$out" | grep -q "^Test passed$"; then
  exit 0
else
  exit 1
fi
